/* bus_pkg.sv */
package bus_pkg;

    localparam int BUS_ADDR_WIDTH = 18;                // Full SPI address space
    localparam int BUS_DATA_WIDTH = 8;                 // Byte-wide bus
    localparam int MEM_ADDR_WIDTH = 10;                // 1 KiB RAM, mirrored
    localparam int MEM_DEPTH      = 1 << MEM_ADDR_WIDTH;
    localparam int REG_SPACE_BIT  = 17;                // 1 = registers, 0 = RAM

    // Register indexes, decoded over addr[16:0]
    localparam logic [REG_SPACE_BIT-1:0] REG_CONFIG_ADDR = 17'd0;   // Straps, read-only
    localparam logic [REG_SPACE_BIT-1:0] REG_STATUS_ADDR = 17'd1;   // LED, read/write

    typedef struct packed {
        logic [BUS_ADDR_WIDTH-1:0] addr;               // Byte address
        logic [BUS_DATA_WIDTH-1:0] wdata;              // Write payload
        logic                      we;                 // 1 = write, 0 = read
    } bus_req_t;

    typedef struct packed {
        logic [BUS_DATA_WIDTH-1:0] rdata;              // Valid with ack
    } bus_rsp_t;

endpackage

/* spi_pkg.sv */
package spi_pkg;

    localparam logic [1:0] SPI_OP_WRITE = 2'b01;       // Header + data byte
    localparam logic [1:0] SPI_OP_READ  = 2'b10;       // Header + dummy byte

    localparam int SPI_HDR_BYTES   = 3;                // Cmd, addr hi, addr lo
    localparam int SPI_FRAME_BYTES = 4;                // Fixed frame length

    // First byte of every frame
    typedef struct packed {
        logic [1:0] op;                                // Opcode
        logic [3:0] rsvd;                              // Ignored
        logic [1:0] addr_hi;                           // Address bits 17:16
    } spi_cmd_t;

    // Remaining header bytes follow MSB first:
    // addr[15:8], then addr[7:0]

endpackage

/* spi_shifter.sv */
`timescale 1ns/100ps

module spi_shifter (
    input  logic       clock_i,                        // System clock
    input  logic       rst_i,                          // Sync reset
    input  logic       spi_cs_ni,                      // Chip select, active low
    input  logic       spi_sck_i,                      // Mode 0 serial clock
    input  logic       spi_sd_i,                       // MCU -> FPGA
    output logic       spi_sd_o,                       // FPGA -> MCU
    input  logic [7:0] tx_byte_i,                      // Next byte to send
    input  logic       tx_load_i,                      // Load tx_byte_i
    output logic [7:0] rx_byte_o,                      // Last complete byte
    output logic       rx_valid_o,                     // One pulse per byte
    output logic       frame_active_o                  // Synced ~cs
);
    logic [1:0] cs_sync;                               // 2-flop synchronizers
    logic [1:0] sck_sync;
    logic [1:0] sd_sync;
    logic       sck_prev;                              // For edge detect
    logic [2:0] bit_cnt;                               // Bit within byte
    logic [6:0] rx_shift;                              // First 7 bits of byte
    logic [7:0] tx_shift;                              // MSB drives sdo
    logic       sck_rise;
    logic       sck_fall;

    always_ff @(posedge clock_i) begin
        if (rst_i) begin
            cs_sync  <= 2'b11;                         // Deselected
            sck_sync <= 2'b00;                         // Mode 0 idle low
            sck_prev <= 1'b0;
        end else begin
            cs_sync  <= {cs_sync[0], spi_cs_ni};
            sck_sync <= {sck_sync[0], spi_sck_i};
            sck_prev <= sck_sync[1];
        end
    end

    always_ff @(posedge clock_i) begin
        sd_sync <= {sd_sync[0], spi_sd_i};             // Same delay as sck
    end

    assign frame_active_o = ~cs_sync[1];
    assign sck_rise       = sck_sync[1] & ~sck_prev & frame_active_o;
    assign sck_fall       = ~sck_sync[1] & sck_prev & frame_active_o;

    always_ff @(posedge clock_i) begin
        if (rst_i) begin
            bit_cnt    <= '0;
            rx_valid_o <= 1'b0;
        end else begin
            rx_valid_o <= 1'b0;
            if (!frame_active_o) begin
                bit_cnt <= '0;                         // cs high restarts framing
            end else if (sck_rise) begin
                bit_cnt    <= bit_cnt + 3'd1;          // Wraps every byte
                rx_valid_o <= (bit_cnt == 3'd7);
            end
        end
    end

    always_ff @(posedge clock_i) begin
        if (sck_rise) begin
            rx_shift <= {rx_shift[5:0], sd_sync[1]};   // Sample on rising edge
            if (bit_cnt == 3'd7) begin
                rx_byte_o <= {rx_shift, sd_sync[1]};
            end
        end
    end

    // No shift on the byte-boundary fall, so a late load still shows its MSB
    always_ff @(posedge clock_i) begin
        if (rst_i || !frame_active_o) begin
            tx_shift <= '0;                            // sdo idles low
        end else if (tx_load_i) begin
            tx_shift <= tx_byte_i;
        end else if (sck_fall && bit_cnt != 3'd0) begin
            tx_shift <= {tx_shift[6:0], 1'b0};         // Change after falling edge
        end
    end

    assign spi_sd_o = tx_shift[7];

    a_rx_in_frame: assert property (@(posedge clock_i) disable iff (rst_i)
        rx_valid_o |-> frame_active_o);

endmodule

/* spi1_controller.sv */
`timescale 1ns/100ps

module spi1_controller (
    input  logic              clock_i,                 // System clock
    input  logic              rst_i,                   // Sync reset
    input  logic              spi_cs_ni,               // Chip select, active low
    input  logic              spi_sck_i,               // Serial clock
    input  logic              spi_sd_i,                // MCU -> FPGA
    output logic              spi_sd_o,                // FPGA -> MCU
    output logic              spi_stall_o,             // Hold sck while high
    output bus_pkg::bus_req_t bus_req_o,               // Held for whole cycle
    output logic              bus_cyc_o,
    input  bus_pkg::bus_rsp_t bus_rsp_i,
    input  logic              bus_ack_i
);
    logic [7:0]        rx_byte;
    logic              rx_valid;
    logic              frame_active;
    logic              tx_load;
    logic [1:0]        byte_cnt;                       // Byte index in frame
    logic [1:0]        op_q;                           // Opcode of current frame
    spi_pkg::spi_cmd_t cmd;
    logic              last_hdr;
    logic              last_data;

    spi_shifter i_shifter (
        .clock_i       (clock_i),
        .rst_i         (rst_i),
        .spi_cs_ni     (spi_cs_ni),
        .spi_sck_i     (spi_sck_i),
        .spi_sd_i      (spi_sd_i),
        .spi_sd_o      (spi_sd_o),
        .tx_byte_i     (bus_rsp_i.rdata),              // Read data straight from bus
        .tx_load_i     (tx_load),
        .rx_byte_o     (rx_byte),
        .rx_valid_o    (rx_valid),
        .frame_active_o(frame_active)
    );

    assign cmd       = spi_pkg::spi_cmd_t'(rx_byte);
    assign last_hdr  = (byte_cnt == 2'(spi_pkg::SPI_HDR_BYTES - 1));
    assign last_data = (byte_cnt == 2'(spi_pkg::SPI_FRAME_BYTES - 1));
    assign tx_load   = bus_cyc_o & bus_ack_i & ~bus_req_o.we;   // Read data returned

    always_ff @(posedge clock_i) begin
        if (rst_i) begin
            byte_cnt    <= '0;
            op_q        <= '0;
            bus_req_o   <= '0;
            bus_cyc_o   <= 1'b0;
            spi_stall_o <= 1'b0;
        end else begin
            if (bus_cyc_o && bus_ack_i) begin
                bus_cyc_o   <= 1'b0;                   // Drop cyc after ack
                spi_stall_o <= 1'b0;                   // Release master
            end

            // An abort only drops the frame; a running cycle still finishes
            if (!frame_active) begin
                byte_cnt <= '0;
            end else if (rx_valid) begin
                byte_cnt <= byte_cnt + 2'd1;
                case (byte_cnt)
                    2'd0: begin
                        op_q <= cmd.op;
                        bus_req_o.addr[bus_pkg::BUS_ADDR_WIDTH-1 -: 2] <= cmd.addr_hi;
                    end
                    2'd1: bus_req_o.addr[15:8] <= rx_byte;
                    default: ;
                endcase

                if (last_hdr) begin
                    bus_req_o.addr[7:0] <= rx_byte;
                    if (op_q == spi_pkg::SPI_OP_READ) begin
                        bus_req_o.we <= 1'b0;
                        bus_cyc_o    <= 1'b1;          // Read issues before dummy byte
                        spi_stall_o  <= 1'b1;
                    end
                end

                if (last_data && op_q == spi_pkg::SPI_OP_WRITE) begin
                    bus_req_o.wdata <= rx_byte;
                    bus_req_o.we    <= 1'b1;
                    bus_cyc_o       <= 1'b1;           // Write issues after data byte
                    spi_stall_o     <= 1'b1;
                end
            end
        end
    end

    a_req_stable: assert property (@(posedge clock_i) disable iff (rst_i)
        bus_cyc_o && !bus_ack_i |=> $stable(bus_req_o));

    a_no_byte_stalled: assert property (@(posedge clock_i) disable iff (rst_i)
        rx_valid |-> !spi_stall_o);

endmodule

/* bus_decoder.sv */
`timescale 1ns/100ps

module bus_decoder (
    input  logic              clock_i,                 // Assertion clock only
    input  logic              rst_i,
    input  bus_pkg::bus_req_t bus_req_i,               // From controller
    input  logic              bus_cyc_i,
    output bus_pkg::bus_rsp_t bus_rsp_o,
    output logic              bus_ack_o,
    output logic              mem_cyc_o,               // RAM select
    input  bus_pkg::bus_rsp_t mem_rsp_i,
    input  logic              mem_ack_i,
    output logic              reg_cyc_o,               // Register select
    input  bus_pkg::bus_rsp_t reg_rsp_i,
    input  logic              reg_ack_i
);
    logic sel_reg;                                     // Register space hit

    assign sel_reg = bus_req_i.addr[bus_pkg::REG_SPACE_BIT];

    assign mem_cyc_o = bus_cyc_i & ~sel_reg;
    assign reg_cyc_o = bus_cyc_i & sel_reg;

    // Address is held for the whole cycle, so the mux stays on one slave
    assign bus_rsp_o = sel_reg ? reg_rsp_i : mem_rsp_i;
    assign bus_ack_o = sel_reg ? reg_ack_i : mem_ack_i;

    a_one_ack: assert property (@(posedge clock_i) disable iff (rst_i)
        !(mem_ack_i && reg_ack_i));

endmodule

/* bram.sv */
`timescale 1ns/100ps

module bram (
    input  logic              wb_clock_i,
    input  logic              wb_reset_i,              // Clears ack only
    input  bus_pkg::bus_req_t wb_req_i,
    input  logic              wb_cycle_i,              // Already decoded
    output bus_pkg::bus_rsp_t wb_rsp_o,
    output logic              wb_ack_o
);
    logic [bus_pkg::BUS_DATA_WIDTH-1:0] mem [bus_pkg::MEM_DEPTH];
    logic [bus_pkg::MEM_ADDR_WIDTH-1:0] index;         // Upper bits mirror
    logic                               serve;

    assign index = wb_req_i.addr[bus_pkg::MEM_ADDR_WIDTH-1:0];
    assign serve = wb_cycle_i & ~wb_ack_o;             // Skip cycle right after ack

    always_ff @(posedge wb_clock_i) begin
        if (serve) begin
            if (wb_req_i.we) begin
                mem[index] <= wb_req_i.wdata;
            end
            wb_rsp_o.rdata <= mem[index];              // Old data on write
        end
    end

    always_ff @(posedge wb_clock_i) begin
        if (wb_reset_i) begin
            wb_ack_o <= 1'b0;
        end else begin
            wb_ack_o <= serve;                         // One-cycle ack pulse
        end
    end

endmodule

/* sys_regs.sv */
`timescale 1ns/100ps

module sys_regs (
    input  logic              clock_i,
    input  logic              rst_i,
    input  bus_pkg::bus_req_t req_i,
    input  logic              cyc_i,                   // Already decoded
    output bus_pkg::bus_rsp_t rsp_o,
    output logic              ack_o,
    input  logic              config_crt_i,            // 0 = 12", 1 = 9"
    input  logic              config_kbd_i,            // 0 = business, 1 = graphics
    output logic              status_no                // LED, active low
);
    logic [1:0]                          crt_sync;     // Async strap inputs
    logic [1:0]                          kbd_sync;
    logic                                led_q;        // 1 = LED on
    logic [bus_pkg::REG_SPACE_BIT-1:0]   reg_idx;
    logic                                serve;

    assign reg_idx = req_i.addr[bus_pkg::REG_SPACE_BIT-1:0];
    assign serve   = cyc_i & ~ack_o;

    always_ff @(posedge clock_i) begin
        crt_sync <= {crt_sync[0], config_crt_i};
        kbd_sync <= {kbd_sync[0], config_kbd_i};
    end

    always_ff @(posedge clock_i) begin
        if (rst_i) begin
            led_q <= 1'b0;                             // LED off
            ack_o <= 1'b0;
        end else begin
            ack_o <= serve;
            if (serve && req_i.we && reg_idx == bus_pkg::REG_STATUS_ADDR) begin
                led_q <= req_i.wdata[0];               // Other indexes ignore writes
            end
        end
    end

    always_ff @(posedge clock_i) begin
        if (serve) begin
            case (reg_idx)
                bus_pkg::REG_CONFIG_ADDR: rsp_o.rdata <= {6'b0, kbd_sync[1], crt_sync[1]};
                bus_pkg::REG_STATUS_ADDR: rsp_o.rdata <= {7'b0, led_q};
                default:                  rsp_o.rdata <= '0;
            endcase
        end
    end

    assign status_no = ~led_q;

endmodule

/* top.sv */
`timescale 1ns/100ps

module top (
    input  logic       clock_i,                        // Board clock, ready to use
    input  logic       rst_i,                          // Sync reset, active high
    output logic       status_no,                      // LED (0 = on, 1 = off)
    input  logic       spi1_cs_ni,                     // SPI1 chip select
    input  logic       spi1_sck_i,                     // SPI1 clock
    input  logic       spi1_sd_i,                      // MCU -> FPGA
    output logic       spi1_sd_o,                      // FPGA -> MCU
    output logic       spi_stall_o,                    // Back-pressure to MCU
    input  logic       config_crt_i,                   // Monitor strap
    input  logic       config_kbd_i,                   // Keyboard strap
    output logic [9:0] spare_o                         // Debug pins
);
    bus_pkg::bus_req_t bus_req;                        // Shared by both slaves
    bus_pkg::bus_rsp_t bus_rsp;
    bus_pkg::bus_rsp_t mem_rsp;
    bus_pkg::bus_rsp_t reg_rsp;
    logic              bus_cyc;
    logic              bus_ack;
    logic              mem_cyc;
    logic              mem_ack;
    logic              reg_cyc;
    logic              reg_ack;

    spi1_controller i_spi1 (
        .clock_i    (clock_i),
        .rst_i      (rst_i),
        .spi_cs_ni  (spi1_cs_ni),
        .spi_sck_i  (spi1_sck_i),
        .spi_sd_i   (spi1_sd_i),
        .spi_sd_o   (spi1_sd_o),
        .spi_stall_o(spi_stall_o),
        .bus_req_o  (bus_req),
        .bus_cyc_o  (bus_cyc),
        .bus_rsp_i  (bus_rsp),
        .bus_ack_i  (bus_ack)
    );

    bus_decoder i_decoder (
        .clock_i  (clock_i),
        .rst_i    (rst_i),
        .bus_req_i(bus_req),
        .bus_cyc_i(bus_cyc),
        .bus_rsp_o(bus_rsp),
        .bus_ack_o(bus_ack),
        .mem_cyc_o(mem_cyc),
        .mem_rsp_i(mem_rsp),
        .mem_ack_i(mem_ack),
        .reg_cyc_o(reg_cyc),
        .reg_rsp_i(reg_rsp),
        .reg_ack_i(reg_ack)
    );

    bram i_bram (
        .wb_clock_i(clock_i),
        .wb_reset_i(rst_i),
        .wb_req_i  (bus_req),
        .wb_cycle_i(mem_cyc),
        .wb_rsp_o  (mem_rsp),
        .wb_ack_o  (mem_ack)
    );

    sys_regs i_regs (
        .clock_i     (clock_i),
        .rst_i       (rst_i),
        .req_i       (bus_req),
        .cyc_i       (reg_cyc),
        .rsp_o       (reg_rsp),
        .ack_o       (reg_ack),
        .config_crt_i(config_crt_i),
        .config_kbd_i(config_kbd_i),
        .status_no   (status_no)
    );

    assign spare_o[7:0] = bus_req.wdata;               // Probe write data
    assign spare_o[8]   = bus_cyc;
    assign spare_o[9]   = bus_ack;

endmodule

/* tb_checker.sv */
`timescale 1ns/100ps

module tb_checker (
    input  logic       clock_i,
    input  logic       rst_i,
    input  logic       cs_ni,                          // Pins as seen at the DUT
    input  logic       sck_i,
    input  logic       mosi_i,
    input  logic       miso_i,
    input  logic       stall_i,
    input  logic       status_ni,
    input  logic       crt_i,
    input  logic       kbd_i,
    input  logic [9:0] spare_i,                        // Write data, cyc, ack
    input  logic       done_i,                         // Stimulus finished
    output int         errors_o
);
    logic [7:0]  mem_model [1024];                     // Mirror of the RAM
    logic        mem_valid [1024];                     // Byte written this run
    logic        led_model;
    logic [31:0] mosi_bits;
    logic [7:0]  miso_bits;                            // Last byte from DUT
    int          n_bits;
    logic        stall_seen;                           // Stall during this frame
    logic        stall_late;                           // Read data byte clocked unstalled
    int          n_acks;                               // Bus acks on the probe pins
    logic [7:0]  ack_wdata;                            // Probed write data at ack
    int          n_tests;
    int          n_unchecked;

    always_ff @(posedge clock_i) begin
        stall_seen <= cs_ni ? 1'b0 : (stall_seen | stall_i);
    end

    always_ff @(posedge clock_i) begin
        if (cs_ni) begin
            n_acks <= 0;
        end else if (spare_i[8] && spare_i[9]) begin
            n_acks    <= n_acks + 1;                   // Cycle closed by ack
            ack_wdata <= spare_i[7:0];
        end
    end

    task automatic judge_frame(input int idx);
        logic [1:0]  op;
        logic [17:0] addr;
        logic [7:0]  exp;
        logic        known;
        logic        want_stall;
        int          exp_acks;
        string       name;

        op         = mosi_bits[31:30];
        addr       = {mosi_bits[25:24], mosi_bits[23:8]};
        name       = $sformatf("frame %0d", idx);
        want_stall = (op == 2'b01) || (op == 2'b10);   // Write or read
        exp_acks   = want_stall ? 1 : 0;
        known      = 1'b1;
        exp        = 8'h00;
        n_tests++;
        if (n_bits < 32) begin
            $display("%s aborted after %0d bits, nothing to apply", name, n_bits);
        end else if (op == 2'b01) begin
            if (addr[17] && addr[16:0] == 17'd1) begin
                led_model = mosi_bits[0];              // Only bit 0 is kept
            end else if (!addr[17]) begin
                mem_model[addr[9:0]] = mosi_bits[7:0];
                mem_valid[addr[9:0]] = 1'b1;
            end
            $display("%s write %05h <= %02h", name, addr, mosi_bits[7:0]);
        end else if (op == 2'b10) begin
            if (addr[17]) begin
                case (addr[16:0])
                    17'd0:   exp = {6'b0, kbd_i, crt_i};
                    17'd1:   exp = {7'b0, led_model};
                    default: exp = 8'h00;              // Unused index
                endcase
            end else begin
                known = mem_valid[addr[9:0]];
                exp   = mem_model[addr[9:0]];
            end
            if (!known) begin
                n_unchecked++;
                $display("%s read %05h not yet written, value %02h not compared",
                         name, addr, miso_bits);
            end else if (miso_bits !== exp) begin
                errors_o++;
                $display("mismatch %s read %05h expected %02h actual %02h",
                         name, addr, exp, miso_bits);
            end else begin
                $display("%s read %05h -> %02h ok", name, addr, miso_bits);
            end
        end else begin
            $display("%s opcode %b ignored", name, op);
        end

        if (n_bits == 32 && stall_seen != want_stall) begin
            errors_o++;
            $display("%s: stall was %0s during the frame", name,
                     stall_seen ? "raised but no bus cycle was due" : "never raised");
        end
        if (n_bits == 32 && n_acks != exp_acks) begin
            errors_o++;
            $display("mismatch %s bus acks expected %0d actual %0d",
                     name, exp_acks, n_acks);
        end else if (n_bits == 32 && op == 2'b01 && ack_wdata !== mosi_bits[7:0]) begin
            errors_o++;
            $display("mismatch %s spare_o write data expected %02h actual %02h",
                     name, mosi_bits[7:0], ack_wdata);
        end
        if (stall_late) begin
            errors_o++;
            $display("%s: stall did not rise before the data byte was clocked", name);
        end
        if (status_ni !== ~led_model) begin
            errors_o++;
            $display("mismatch %s status_no expected %b actual %b",
                     name, ~led_model, status_ni);
        end
    endtask

    initial begin
        int n_frames;

        errors_o    = 0;
        n_tests     = 0;
        n_unchecked = 0;
        n_frames    = 0;
        led_model   = 1'b0;                            // LED off after reset
        for (int i = 0; i < 1024; i++) begin
            mem_valid[i] = 1'b0;
        end

        @(negedge rst_i);
        n_tests++;
        if (status_ni !== 1'b1 || stall_i !== 1'b0 || miso_i !== 1'b0
            || spare_i !== 10'd0) begin
            errors_o++;
            $display("reset: outputs not idle, status_no %b stall %b sdo %b spare %03h",
                     status_ni, stall_i, miso_i, spare_i);
        end else begin
            $display("reset ok");
        end

        forever begin
            @(negedge cs_ni or posedge done_i);
            if (done_i) begin
                break;
            end
            n_bits     = 0;
            stall_late = 1'b0;
            mosi_bits  = '0;
            miso_bits  = '0;
            while (!cs_ni) begin
                @(posedge sck_i or posedge cs_ni);
                if (!cs_ni) begin                      // sck edge, not frame end
                    if (n_bits == 24 && mosi_bits[23:22] == 2'b10 && !stall_seen) begin
                        stall_late = 1'b1;             // Read cycle not yet stalled
                    end
                    mosi_bits = {mosi_bits[30:0], mosi_i};
                    if (n_bits >= 24) begin
                        miso_bits = {miso_bits[6:0], miso_i};
                    end
                    n_bits++;
                end
            end
            judge_frame(n_frames);
            n_frames++;
        end

        if (stall_i) begin
            errors_o++;
            $display("stall still high after the last frame");
        end
        $display("tests %0d, errors %0d, reads not compared %0d",
                 n_tests, errors_o, n_unchecked);
    end

endmodule

/* tb_top.sv */
`timescale 1ns/100ps

module tb_top;
    localparam int N_FRAMES   = 300;
    localparam int CLK_NS     = 100;
    localparam int MARGIN_NS  = 200_000;               // Reset plus slack
    localparam int TIMEOUT_NS = N_FRAMES * 40 * 8 * CLK_NS + MARGIN_NS;

    logic        clock;
    logic        rst;
    logic        cs_n;
    logic        sck;
    logic        sdi;
    logic        sdo;
    logic        stall;
    logic        status_n;
    logic        crt;
    logic        kbd;
    logic [9:0]  spare;
    logic [15:0] lfsr;                                 // Galois LFSR state
    logic        done;
    int          errors;

    top i_top (
        .clock_i     (clock),
        .rst_i       (rst),
        .status_no   (status_n),
        .spi1_cs_ni  (cs_n),
        .spi1_sck_i  (sck),
        .spi1_sd_i   (sdi),
        .spi1_sd_o   (sdo),
        .spi_stall_o (stall),
        .config_crt_i(crt),
        .config_kbd_i(kbd),
        .spare_o     (spare)
    );

    tb_checker i_checker (
        .clock_i  (clock),
        .rst_i    (rst),
        .cs_ni    (cs_n),
        .sck_i    (sck),
        .mosi_i   (sdi),
        .miso_i   (sdo),
        .stall_i  (stall),
        .status_ni(status_n),
        .crt_i    (crt),
        .kbd_i    (kbd),
        .spare_i  (spare),
        .done_i   (done),
        .errors_o (errors)
    );

    initial begin
        clock = 1'b0;
        forever #(CLK_NS / 2) clock = ~clock;
    end

    // Right-shift form, taps 16,14,13,11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    task automatic draw_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);                    // One step per bit
            v    = {v[30:0], lfsr[0]};
        end
    endtask

    task automatic wait_unstalled();
        while (stall) begin
            @(negedge clock);                          // Back-pressure from DUT
        end
    endtask

    // Mode 0, MSB first, sck 4 clocks high and 4 low
    task automatic spi_frame(input logic [31:0] frame, input int n_bytes);
        cs_n = 1'b0;
        repeat (4) @(negedge clock);
        for (int b = 0; b < n_bytes * 8; b++) begin
            sdi = frame[31 - b];
            wait_unstalled();
            sck = 1'b1;
            repeat (4) @(negedge clock);
            sck = 1'b0;
            repeat (4) @(negedge clock);
        end
        repeat (2) @(negedge clock);                   // Let stall rise
        wait_unstalled();
        cs_n = 1'b1;
        sdi  = 1'b0;
        repeat (6) @(negedge clock);
    endtask

    initial begin
        logic [31:0] r;
        logic [31:0] frame;
        logic [1:0]  op;
        logic [17:0] addr;
        logic [7:0]  data;
        int          n_bytes;

        rst  = 1'b1;
        cs_n = 1'b1;
        sck  = 1'b0;
        sdi  = 1'b0;
        crt  = 1'b0;
        kbd  = 1'b0;
        done = 1'b0;
        lfsr = 16'd19091;
        repeat (8) @(negedge clock);
        rst = 1'b0;
        repeat (4) @(negedge clock);

        for (int f = 0; f < N_FRAMES; f++) begin
            draw_bits(2, r);
            crt = r[0];                                // Straps change between frames
            kbd = r[1];
            draw_bits(3, r);
            if (r[2:0] == 3'd0) begin
                op = 2'b11;                            // Illegal opcode now and then
            end else begin
                op = r[0] ? spi_pkg::SPI_OP_READ : spi_pkg::SPI_OP_WRITE;
            end
            draw_bits(2, r);
            if (r[1:0] == 2'd0) begin
                draw_bits(2, r);
                addr = {1'b1, 15'd0, r[1:0]};          // Index 2 and 3 unused
            end else begin
                draw_bits(11, r);
                addr = {1'b0, r[10:4], 6'b000000, r[3:0]};   // Aliases over 16 bytes
            end
            draw_bits(8, r);
            data = r[7:0];
            draw_bits(3, r);
            if (r[2:0] == 3'd0) begin
                draw_bits(2, r);
                n_bytes = (r[1:0] % 3) + 1;            // Early cs abort
            end else begin
                n_bytes = 4;
            end
            frame = {op, 4'b0000, addr[17:16], addr[15:8], addr[7:0],
                     (op == spi_pkg::SPI_OP_READ) ? 8'h00 : data};
            spi_frame(frame, n_bytes);
        end

        done = 1'b1;
        @(negedge clock);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("Run timed out: a frame or a stall never finished");
        $display("=== FAIL ===");
        $finish;
    end

endmodule

/* vlog.f */
bus_pkg.sv
spi_pkg.sv
spi_shifter.sv
spi1_controller.sv
bus_decoder.sv
bram.sv
sys_regs.sv
top.sv
tb_checker.sv
tb_top.sv

/* run.sh */
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and look for the pass line
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f vlog.f --top-module tb_top -o tb_top_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/tb_top_sim)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx '=== PASS ==='; then
    exit 0
fi
exit 1
